// File: flist.f
isa_pkg.sv
rs_pkg.sv
rename_dispatch.sv
rs_entry.sv
issue_alu.sv
tomasulo_core.sv
tomasulo_asserts.sv
tb_tomasulo.sv

// File: Bender.yml
package:
  name: tomasulo_core

sources:
  - isa_pkg.sv
  - rs_pkg.sv
  - rename_dispatch.sv
  - rs_entry.sv
  - issue_alu.sv
  - tomasulo_core.sv
  - target: test
    files:
      - tomasulo_asserts.sv
      - tb_tomasulo.sv

// File: tb_tomasulo.sv
////////////////////////////////////////
// Testbench for the Tomasulo issue core
// Directed and random dispatch against
// an in-order reference model
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_tomasulo;

    import isa_pkg::*;
    import rs_pkg::*;

    // About 350 instructions at a few cycles each, plus reset and drains
    localparam int NUM_RANDOM = 300;
    localparam int MAX_CYCLES = 5 * (NUM_RANDOM + 50) + 250;

    // A full station drains well inside this
    localparam int DRAIN_CYCLES = 4 * NUM_RS + 4;

    // Expected broadcast, kept until the CDB shows it
    typedef struct packed {
        reg_idx_t rd;
        data_t    value;
    } result_t;

    logic           clock;
    logic           reset;
    logic           dispatch_valid;
    dispatch_inst_t dispatch_inst;
    logic           dispatch_ready;
    cdb_t           cdb;

    data_t       model_regs [NUM_ARCH_REGS];
    result_t     pending [$];
    string       test_name;
    int          errors;
    int          cycles;
    logic        stall_seen;

    tomasulo_core u_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb)
    );

    bind tomasulo_core tomasulo_asserts u_asserts (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .grant          (grant),
        .cdb            (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////

    function automatic data_t expected_result(input alu_op_e op, input data_t a,
                                              input data_t b, input logic [IMM_W-1:0] imm);
        case (op)
            OP_LI:   return {{(XLEN - IMM_W){1'b0}}, imm};
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    // Model runs in program order at dispatch time
    task automatic send_inst(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                             input reg_idx_t rs2, input logic [IMM_W-1:0] imm);
        result_t res;
        while (!dispatch_ready) begin
            stall_seen = 1'b1;
            @(posedge clock);
            #1;
        end
        dispatch_inst.op  = op;
        dispatch_inst.rd  = rd;
        dispatch_inst.rs1 = rs1;
        dispatch_inst.rs2 = rs2;
        dispatch_inst.imm = imm;
        dispatch_valid    = 1'b1;
        res.rd            = rd;
        res.value         = expected_result(op, model_regs[rs1], model_regs[rs2], imm);
        model_regs[rd]    = res.value;
        pending.push_back(res);
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // Results may complete out of order, so match any pending pair
    task automatic check_broadcast(input reg_idx_t rd, input data_t value);
        int hit;
        int oldest;
        hit    = -1;
        oldest = -1;
        foreach (pending[i]) begin
            if (pending[i].rd == rd && oldest < 0) begin
                oldest = i;
            end
            if (pending[i].rd == rd && pending[i].value == value && hit < 0) begin
                hit = i;
            end
        end
        assert (hit >= 0) begin
            pending.delete(hit);
        end else begin
            errors++;
            if (oldest >= 0) begin
                $display("Error: %s x%0d expected %h actual %h",
                         test_name, rd, pending[oldest].value, value);
            end else begin
                $display("%s: broadcast to x%0d with nothing pending", test_name, rd);
            end
        end
    endtask

    // Bounded wait for every pending result to broadcast
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            #1;
            waited++;
        end
        assert (pending.size() == 0) else begin
            errors++;
            $display("%s: %0d results never broadcast", test_name, pending.size());
        end
        assert (dispatch_ready) else begin
            errors++;
            $display("%s: dispatch_ready low with the station drained", test_name);
        end
    endtask

    task automatic print_error_counts();
        $display("Errors: model %0d, assertions %0d", errors, u_dut.u_asserts.fail_count);
    endtask

    // Registered output, sampled mid cycle
    always @(negedge clock) begin
        if (!reset && cdb.valid) begin
            check_broadcast(cdb.rd, cdb.value);
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            print_error_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h7d26));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_inst  = '0;
        errors         = 0;
        cycles         = 0;
        stall_seen     = 1'b0;
        test_name      = "reset";
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        // Idle bus after reset
        repeat (3) begin
            @(posedge clock);
            #1;
            assert (!cdb.valid && dispatch_ready) else begin
                errors++;
                $display("reset: bus active or dispatch blocked while idle");
            end
        end

        test_name = "load_imm";
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            send_inst(OP_LI, reg_idx_t'(r), 3'd0, 3'd0, IMM_W'($urandom));
        end
        wait_drain();

        // Each step reads the one before it
        test_name = "dep_chain";
        send_inst(OP_LI, 3'd1, 3'd0, 3'd0, 16'h1234);
        send_inst(OP_LI, 3'd2, 3'd0, 3'd0, 16'h00ff);
        send_inst(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0);
        send_inst(OP_SUB, 3'd4, 3'd3, 3'd2, 16'h0);
        send_inst(OP_AND, 3'd5, 3'd4, 3'd3, 16'h0);
        send_inst(OP_OR, 3'd6, 3'd5, 3'd1, 16'h0);
        send_inst(OP_XOR, 3'd7, 3'd6, 3'd5, 16'h0);
        wait_drain();

        // Same rd renamed over and over
        test_name = "waw_rename";
        for (int k = 0; k < 4; k++) begin
            send_inst(OP_LI, 3'd1, 3'd0, 3'd0, IMM_W'(16'h0101 * (k + 1)));
            send_inst(OP_ADD, 3'd2, 3'd1, 3'd1, 16'h0);
            send_inst(OP_XOR, 3'd1, 3'd1, 3'd2, 16'h0);
            send_inst(OP_OR, 3'd3, 3'd1, 3'd2, 16'h0);
        end
        wait_drain();

        // Long chain outruns the ALU and fills the station
        test_name  = "station_full";
        stall_seen = 1'b0;
        send_inst(OP_LI, 3'd4, 3'd0, 3'd0, 16'h0003);
        send_inst(OP_LI, 3'd5, 3'd0, 3'd0, 16'h0005);
        for (int k = 0; k < 4 * NUM_RS; k++) begin
            send_inst(OP_ADD, 3'd4, 3'd4, 3'd5, 16'h0);
        end
        assert (stall_seen) else begin
            errors++;
            $display("station_full: dispatch_ready never went low");
        end
        wait_drain();

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_inst(alu_op_e'($urandom_range(0, 5)), reg_idx_t'($urandom),
                      reg_idx_t'($urandom), reg_idx_t'($urandom), IMM_W'($urandom));
        end
        wait_drain();

        repeat (4) @(posedge clock);
        print_error_counts();
        if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tomasulo_asserts.sv
////////////////////////////////////////
// Tomasulo core protocol checks
// Grant shape, CDB tag, dispatch
// liveness and post-reset state
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tomasulo_asserts (
    input logic                      clock,
    input logic                      reset,
    input logic                      dispatch_valid,
    input logic                      dispatch_ready,
    input logic [rs_pkg::NUM_RS-1:0] grant,
    input rs_pkg::cdb_t              cdb
);

    import rs_pkg::*;

    // Running count of failed properties
    int unsigned fail_count = 0;

    // At most one entry issues per cycle
    grant_onehot0: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
        else begin
            fail_count++;
            $error("grant has more than one bit set");
        end

    // A broadcast names the entry granted the cycle before
    cdb_tag_valid: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag != TAG_NONE)
            && ($past(grant) == (NUM_RS'(1) << (cdb.tag - 1'b1))))
        else begin
            fail_count++;
            $error("CDB tag does not name the granted entry");
        end

    // Accepted work leads to some broadcast within the bound
    dispatch_live: assert property (@(posedge clock) disable iff (reset)
        (dispatch_valid && dispatch_ready) |-> ##[1:4*NUM_RS+4] cdb.valid)
        else begin
            fail_count++;
            $error("no CDB broadcast after accepted dispatch");
        end

    // Station empty and bus quiet right after reset
    reset_state: assert property (@(posedge clock) $fell(reset) |-> (dispatch_ready && !cdb.valid))
        else begin
            fail_count++;
            $error("wrong state in cycle after reset");
        end

endmodule

`default_nettype wire

// File: tomasulo_core.sv
////////////////////////////////////////
// Tomasulo issue core top level
// Dispatch, reservation entries, issue
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tomasulo_core (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  rs_pkg::dispatch_inst_t dispatch_inst,
    output logic                   dispatch_ready,
    output rs_pkg::cdb_t           cdb
);

    import rs_pkg::*;

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    // One bit per entry
    logic [NUM_RS-1:0] alloc;
    logic [NUM_RS-1:0] busy;
    logic [NUM_RS-1:0] ready;
    logic [NUM_RS-1:0] grant;

    // Shared fill bus to every entry
    rs_fill_t fill;

    // Entry payloads toward the ALU
    rs_payload_t [NUM_RS-1:0] payload;

    ////////////////////////////////////////
    // Rename and dispatch
    ////////////////////////////////////////

    rename_dispatch u_rename_dispatch (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .busy           (busy),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .alloc          (alloc),
        .fill           (fill)
    );

    ////////////////////////////////////////
    // Reservation station entries
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        rs_entry u_rs_entry (
            .clock   (clock),
            .reset   (reset),
            .alloc   (alloc[i]),
            .fill    (fill),
            .cdb     (cdb),
            .grant   (grant[i]),
            .busy    (busy[i]),
            .ready   (ready[i]),
            .payload (payload[i])
        );
    end

    // Issue select, ALU and CDB driver
    issue_alu u_issue_alu (
        .clock   (clock),
        .reset   (reset),
        .ready   (ready),
        .payload (payload),
        .grant   (grant),
        .cdb     (cdb)
    );

endmodule

`default_nettype wire

// File: issue_alu.sv
////////////////////////////////////////
// Issue select and ALU
// Fixed priority grant, one result per
// cycle, registered CDB broadcast
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module issue_alu (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [rs_pkg::NUM_RS-1:0]               ready,
    input  rs_pkg::rs_payload_t [rs_pkg::NUM_RS-1:0] payload,
    output logic [rs_pkg::NUM_RS-1:0]               grant,
    output rs_pkg::cdb_t                            cdb
);

    import isa_pkg::*;
    import rs_pkg::*;

    logic [RS_IDX_W-1:0] sel_idx;
    logic                sel_valid;
    rs_payload_t         sel;
    data_t               result;

    ////////////////////////////////////////
    // Select
    ////////////////////////////////////////

    // Lowest ready index has priority
    always_comb begin
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_idx   = RS_IDX_W'(i);
                sel_valid = 1'b1;
            end
        end
    end

    assign grant = sel_valid ? (NUM_RS'(1) << sel_idx) : '0;
    assign sel   = payload[sel_idx];

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    always_comb begin
        case (sel.op)
            OP_LI:   result = {{(XLEN - IMM_W){1'b0}}, sel.imm};
            OP_ADD:  result = sel.v1 + sel.v2;
            OP_SUB:  result = sel.v1 - sel.v2;
            OP_AND:  result = sel.v1 & sel.v2;
            OP_OR:   result = sel.v1 | sel.v2;
            OP_XOR:  result = sel.v1 ^ sel.v2;
            default: result = '0;
        endcase
    end

    // Broadcast one cycle after grant
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= sel_valid;
        end
        // Tag names the entry that produced it
        cdb.tag   <= rs_tag_t'(sel_idx) + rs_tag_t'(1);
        cdb.rd    <= sel.rd;
        cdb.value <= result;
    end

endmodule

`default_nettype wire

// File: rs_entry.sv
////////////////////////////////////////
// Reservation station entry
// Holds one instruction, snoops the CDB
// for missing operands, frees on grant
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rs_entry (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,
    input  rs_pkg::rs_fill_t    fill,
    input  rs_pkg::cdb_t        cdb,
    input  logic                grant,
    output logic                busy,
    output logic                ready,
    output rs_pkg::rs_payload_t payload
);

    import rs_pkg::*;

    // Pending producer per source
    rs_tag_t t1;
    rs_tag_t t2;

    logic hit1;
    logic hit2;

    // Snoop only while occupied
    assign hit1 = busy && cdb.valid && (t1 != TAG_NONE) && (t1 == cdb.tag);
    assign hit2 = busy && cdb.valid && (t2 != TAG_NONE) && (t2 == cdb.tag);

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            t1   <= TAG_NONE;
            t2   <= TAG_NONE;
        end else if (alloc) begin
            busy <= 1'b1;
            t1   <= fill.t1;
            t2   <= fill.t2;
        end else begin
            // Free at the grant edge
            if (grant) begin
                busy <= 1'b0;
            end
            if (hit1) begin
                t1 <= TAG_NONE;
            end
            if (hit2) begin
                t2 <= TAG_NONE;
            end
        end
    end

    ////////////////////////////////////////
    // Operand payload
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            payload <= fill.payload;
        end else begin
            // Capture broadcast value
            if (hit1) begin
                payload.v1 <= cdb.value;
            end
            if (hit2) begin
                payload.v2 <= cdb.value;
            end
        end
    end

    // Both sources present
    assign ready = busy && (t1 == TAG_NONE) && (t2 == TAG_NONE);

endmodule

`default_nettype wire

// File: rename_dispatch.sv
////////////////////////////////////////
// Rename and dispatch
// Register file, map table, operand read
// with CDB bypass, free entry allocation
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rename_dispatch (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  rs_pkg::dispatch_inst_t    dispatch_inst,
    input  logic [rs_pkg::NUM_RS-1:0] busy,
    input  rs_pkg::cdb_t              cdb,
    output logic                      dispatch_ready,
    output logic [rs_pkg::NUM_RS-1:0] alloc,
    output rs_pkg::rs_fill_t          fill
);

    import isa_pkg::*;
    import rs_pkg::*;

    // Architectural state
    data_t   regs    [NUM_ARCH_REGS];
    rs_tag_t map_tag [NUM_ARCH_REGS];

    logic [NUM_RS-1:0]   free_onehot;
    logic [RS_IDX_W-1:0] free_idx;
    rs_tag_t             new_tag;
    logic                accept;
    logic                uses_src;
    rs_tag_t             raw_t1;
    rs_tag_t             raw_t2;

    // True when the CDB is delivering this producer now
    function automatic logic cdb_hit(input rs_tag_t t, input cdb_t c);
        return c.valid && (t != TAG_NONE) && (t == c.tag);
    endfunction

    ////////////////////////////////////////
    // Free entry search
    ////////////////////////////////////////

    // Lowest free index wins
    always_comb begin
        free_onehot = '0;
        free_idx    = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_onehot    = '0;
                free_onehot[i] = 1'b1;
                free_idx       = RS_IDX_W'(i);
            end
        end
    end

    assign dispatch_ready = |(~busy);
    assign accept         = dispatch_valid && dispatch_ready;
    assign alloc          = accept ? free_onehot : '0;
    assign new_tag        = rs_tag_t'(free_idx) + rs_tag_t'(1);

    ////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////

    // Load immediate never waits on its sources
    assign uses_src = (dispatch_inst.op != OP_LI);
    assign raw_t1   = uses_src ? map_tag[dispatch_inst.rs1] : TAG_NONE;
    assign raw_t2   = uses_src ? map_tag[dispatch_inst.rs2] : TAG_NONE;

    always_comb begin
        fill.payload.op  = dispatch_inst.op;
        fill.payload.rd  = dispatch_inst.rd;
        fill.payload.imm = dispatch_inst.imm;
        // Bypass a value broadcast in this same cycle
        fill.payload.v1  = cdb_hit(raw_t1, cdb) ? cdb.value : regs[dispatch_inst.rs1];
        fill.payload.v2  = cdb_hit(raw_t2, cdb) ? cdb.value : regs[dispatch_inst.rs2];
        fill.t1          = cdb_hit(raw_t1, cdb) ? TAG_NONE : raw_t1;
        fill.t2          = cdb_hit(raw_t2, cdb) ? TAG_NONE : raw_t2;
    end

    ////////////////////////////////////////
    // Map table and register file update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                regs[r]    <= '0;
                map_tag[r] <= TAG_NONE;
            end
        end else begin
            // Only the youngest producer of rd may retire it
            if (cdb_hit(map_tag[cdb.rd], cdb)) begin
                regs[cdb.rd]    <= cdb.value;
                map_tag[cdb.rd] <= TAG_NONE;
            end
            // Later assignment, so a new rename beats the clear
            if (accept) begin
                map_tag[dispatch_inst.rd] <= new_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: rs_pkg.sv
////////////////////////////////////////
// Reservation station definitions
// Entry count, tags, and the structs
// passed between dispatch, entries, CDB
////////////////////////////////////////

`default_nettype none

package rs_pkg;

    import isa_pkg::*;

    ////////////////////////////////////////
    // Station sizing and tags
    ////////////////////////////////////////

    localparam int NUM_RS   = 4;
    localparam int RS_IDX_W = $clog2(NUM_RS);

    // One spare code for "value present"
    localparam int TAG_W = $clog2(NUM_RS + 1);

    typedef logic [TAG_W-1:0] rs_tag_t;

    // Zero means no producer; entry k is tag k+1
    localparam rs_tag_t TAG_NONE = '0;

    // Immediate field, zero extended by the ALU
    localparam int IMM_W = 16;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    // Instruction as offered on the dispatch port
    typedef struct packed {
        alu_op_e          op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [IMM_W-1:0] imm;
    } dispatch_inst_t;

    // What an entry hands to the ALU on grant
    typedef struct packed {
        alu_op_e          op;
        reg_idx_t         rd;
        data_t            v1;
        data_t            v2;
        logic [IMM_W-1:0] imm;
    } rs_payload_t;

    // Dispatch write into a free entry
    typedef struct packed {
        rs_payload_t payload;
        rs_tag_t     t1;
        rs_tag_t     t2;
    } rs_fill_t;

    // Common data bus broadcast
    typedef struct packed {
        logic     valid;
        rs_tag_t  tag;
        reg_idx_t rd;
        data_t    value;
    } cdb_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
////////////////////////////////////////
// Architectural definitions
// Data width, register file size and
// the ALU opcode set of the issue core
////////////////////////////////////////

`default_nettype none

package isa_pkg;

    ////////////////////////////////////////
    // Word and register file geometry
    ////////////////////////////////////////

    // Datapath width in bits
    localparam int XLEN = 32;

    // Architectural registers visible to software
    localparam int NUM_ARCH_REGS = 8;
    localparam int REG_IDX_W = $clog2(NUM_ARCH_REGS);

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      data_t;

    ////////////////////////////////////////
    // ALU opcodes
    ////////////////////////////////////////

    // OP_LI ignores both sources and returns the immediate
    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5
    } alu_op_e;

endpackage

`default_nettype wire
